//--- compile.f
hw/env_pkg.sv
hw/op_delay_line.sv
hw/op_state_mem.sv
hw/env_rate_counter.sv
hw/env_attenuation.sv
hw/env_gen_top.sv
verif/env_gen_tb.sv

//--- Makefile
# Verilator build and run for the envelope generator testbench.

TOP = env_gen_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

# the run passes only when the pass message shows up in the output.
run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- verif/env_gen_tests.txt
// repeats bank op key_on ksr nts fnum block attack decay sustain release level, all hex.
// level is the expected env_level after the last of the repeated visits.
1 0 00 0 0 0 000 0 0 0 0 0 1ff
1 1 11 0 0 0 000 0 0 0 0 0 1ff
// attack at rate 15, effective 60.
5 0 01 1 0 0 000 0 f 0 0 0 077
a 0 01 1 0 0 000 0 f 0 0 0 000
// attack, decay to sustain level 4, then hold.
f 0 02 1 0 0 000 0 f f 4 0 000
10 0 02 1 0 0 000 0 f f 4 0 040
10 0 02 1 0 0 000 0 f f 4 0 080
8 0 02 1 0 0 000 0 f f 4 0 080
30 0 02 0 0 0 000 0 f f 4 f 140
30 0 02 0 0 0 000 0 f f 4 f 1ff
4 0 02 0 0 0 000 0 f f 4 f 1ff
// slow release at rate 1 holds the level.
5 0 03 1 0 0 000 0 f 0 0 1 077
28 0 03 0 0 0 000 0 f 0 0 1 077
// key scaling clamps attack 14 to effective 60.
5 0 04 1 1 0 200 7 e 0 4 0 077
a 0 04 1 1 0 200 7 e 0 4 0 000
6 0 04 1 1 0 200 7 e 0 4 0 000
3 0 05 1 0 0 000 0 f 0 0 0 0d7
5 0 05 1 1 0 200 7 0 0 0 0 0d7
4 0 05 0 1 0 200 7 0 0 0 0 0d7
1 0 05 1 0 0 000 0 f 0 0 0 09f
// same operator in both banks, interleaved.
5 0 07 1 0 0 000 0 f 0 0 0 077
5 1 07 1 0 0 000 0 d 0 0 0 170
3 0 07 1 0 0 000 0 f 0 0 0 02f
3 1 07 1 0 0 000 0 d 0 0 0 12d
2 1 10 1 0 0 000 0 f 0 0 0 11f
2 1 0c 1 0 0 000 0 d 0 0 0 1c1
2 0 11 0 0 0 000 0 0 0 0 f 1ff

//--- verif/env_gen_tb.sv
//####################
// testbench: clock, reset, test file reader,
// strobe driver, scoreboard and watchdog.
//####################
`timescale 1ns/10ps
`default_nettype none

module env_gen_tb;

    localparam int NUM_BANKS = 2;
    localparam int OPS_PER_BANK = 18;
    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int OP_W = $clog2(OPS_PER_BANK);
    localparam string TESTS_FILE = "verif/env_gen_tests.txt";

    // one record of the test file.
    typedef struct packed {
        logic [15:0] reps;
        logic [BANK_W-1:0] bank;
        logic [OP_W-1:0] op;
        logic key;
        logic ksr;
        logic nts;
        logic [9:0] fnum;
        logic [2:0] block;
        logic [3:0] ar;
        logic [3:0] dr;
        logic [3:0] sl;
        logic [3:0] rr;
        logic [8:0] level;                          // after the last visit.
    } test_rec_t;

    // one strobe waiting for its env_valid.
    typedef struct packed {
        logic [31:0] cyc;
        logic [BANK_W-1:0] bank;
        logic [OP_W-1:0] op;
        logic final_visit;
        logic [8:0] level;
    } exp_entry_t;

    logic clk = 1'b0;
    logic arst_n;
    logic slot_en;
    logic [BANK_W-1:0] bank_num;
    logic [OP_W-1:0] op_num;
    logic key_on;
    logic ksr;
    logic nts;
    logic [9:0] fnum;
    logic [2:0] block;
    logic [3:0] attack_rate;
    logic [3:0] decay_rate;
    logic [3:0] sustain_level;
    logic [3:0] release_rate;
    logic env_valid;
    logic [BANK_W-1:0] env_bank;
    logic [OP_W-1:0] env_op;
    logic [8:0] env_level;

    test_rec_t tests[$];
    exp_entry_t exp_q[$];                           // scoreboard, oldest first.
    int cycle = 0;
    int unsigned checked = 0;
    int unsigned total_reps = 0;
    int unsigned limit_cycles = 0;
    bit tests_loaded = 1'b0;

    env_gen_top #(
        .NUM_BANKS(NUM_BANKS),
        .OPS_PER_BANK(OPS_PER_BANK)
    ) i_env_gen_top (
        .clk, .arst_n, .slot_en, .bank_num, .op_num, .key_on,
        .ksr, .nts, .fnum, .block,
        .attack_rate, .decay_rate, .sustain_level, .release_rate,
        .env_valid, .env_bank, .env_op, .env_level
    );

    always #20 clk = ~clk;                          // 40 ns period.

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input int actual, input int expected);
        if (actual != expected) begin
            abort_run($sformatf("Fail at %0t: %s is %0d, expected %0d",
                                $time, what, actual, expected));
        end
    endtask

    // comment lines start with //, data lines hold 13 hex columns.
    task automatic load_tests();
        int fd;
        int fields;
        string line;
        test_rec_t r;
        int unsigned f[13];
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            abort_run({"could not open the test file ", TESTS_FILE});
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (!(line.len() >= 2 && line.substr(0, 1) == "//")) begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                     f[7], f[8], f[9], f[10], f[11], f[12]);
                    if (fields == 13) begin
                        r = {16'(f[0]), BANK_W'(f[1]), OP_W'(f[2]), 1'(f[3]), 1'(f[4]),
                             1'(f[5]), 10'(f[6]), 3'(f[7]), 4'(f[8]), 4'(f[9]),
                             4'(f[10]), 4'(f[11]), 9'(f[12])};
                        tests.push_back(r);
                        total_reps += f[0];
                    end else if (fields > 0) begin
                        abort_run({"malformed line in the test file: ", line});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // consecutive records with equal repeat counts and distinct operators
    // are visited round robin, one strobe per cycle.
    function automatic int group_end(input int first);
        int last;
        bit clash;
        last = first + 1;
        clash = 1'b0;
        while (!clash && last < tests.size() && tests[last].reps == tests[first].reps) begin
            for (int k = first; k < last; k++) begin
                if (tests[k].bank == tests[last].bank && tests[k].op == tests[last].op) begin
                    clash = 1'b1;
                end
            end
            if (!clash) begin
                last++;
            end
        end
        return last;
    endfunction

    task automatic drive_visit(input test_rec_t r, input bit last_visit);
        exp_entry_t e;
        @(negedge clk);
        slot_en = 1'b1;
        bank_num = r.bank;
        op_num = r.op;
        key_on = r.key;
        ksr = r.ksr;
        nts = r.nts;
        fnum = r.fnum;
        block = r.block;
        attack_rate = r.ar;
        decay_rate = r.dr;
        sustain_level = r.sl;
        release_rate = r.rr;
        e = {32'(cycle), r.bank, r.op, last_visit, r.level};
        exp_q.push_back(e);
    endtask

    // 3 to 6 idle cycles keep revisits past the write-back.
    task automatic idle_gap();
        int unsigned gap;
        gap = 3 + $urandom % 4;
        @(negedge clk);
        slot_en = 1'b0;
        repeat (gap - 1) @(negedge clk);
    endtask

    // scoreboard, outputs are registered so the falling edge sees them settled.
    always @(negedge clk) begin : monitor
        exp_entry_t e;
        if (env_valid) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("env_valid was raised at %0t with no strobe pending",
                                    $time));
            end else begin
                e = exp_q.pop_front();
                check_value("env_valid delay in cycles", cycle - int'(e.cyc), 2);
                check_value("env_bank", int'(env_bank), int'(e.bank));
                check_value("env_op", int'(env_op), int'(e.op));
                if (e.final_visit) begin
                    check_value("env_level", int'(env_level), int'(e.level));
                end
                checked++;
            end
        end
    end

    initial begin : watchdog
        wait (tests_loaded);
        repeat (limit_cycles) @(posedge clk);
        abort_run($sformatf("timeout: the run went past %0d cycles", limit_cycles));
    end

    initial begin : main
        int idx;
        int last;
        $timeformat(-9, 0, " ns", 0);
        arst_n = 1'b0;
        slot_en = 1'b0;
        bank_num = '0;
        op_num = '0;
        key_on = 1'b0;
        ksr = 1'b0;
        nts = 1'b0;
        fnum = '0;
        block = '0;
        attack_rate = '0;
        decay_rate = '0;
        sustain_level = '0;
        release_rate = '0;
        void'($urandom(32'ha679));
        load_tests();
        limit_cycles = total_reps * 8 + 100;
        tests_loaded = 1'b1;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        idx = 0;
        while (idx < tests.size()) begin
            last = group_end(idx);
            for (int round = 0; round < int'(tests[idx].reps); round++) begin
                for (int k = idx; k < last; k++) begin
                    drive_visit(tests[k], round == int'(tests[idx].reps) - 1);
                end
                idle_gap();
            end
            idx = last;
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        if (tests.size() != 0 && checked == total_reps) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("only %0d of %0d visits were checked", checked, total_reps));
        end
    end

endmodule

`default_nettype wire

//--- hw/env_gen_top.sv
//####################
// envelope generator top level.
//####################
`timescale 1ns/10ps
`default_nettype none

module env_gen_top #(
    parameter int NUM_BANKS = 2,
    parameter int OPS_PER_BANK = 18
) (
    input wire clk,
    input wire arst_n,
    input wire slot_en,                             // one cycle per visit.
    input wire [$clog2(NUM_BANKS)-1:0] bank_num,
    input wire [$clog2(OPS_PER_BANK)-1:0] op_num,
    input wire key_on,
    input wire ksr,
    input wire nts,
    input wire env_pkg::fnum_t fnum,
    input wire env_pkg::block_t block,
    input wire env_pkg::env_rate_t attack_rate,
    input wire env_pkg::env_rate_t decay_rate,
    input wire env_pkg::sustain_lvl_t sustain_level,
    input wire env_pkg::env_rate_t release_rate,
    output logic env_valid,                         // slot_en + 2.
    output logic [$clog2(NUM_BANKS)-1:0] env_bank,
    output logic [$clog2(OPS_PER_BANK)-1:0] env_op,
    output env_pkg::env_level_t env_level
);

    import env_pkg::*;

    localparam int TAG_W = $clog2(NUM_BANKS) + $clog2(OPS_PER_BANK);

    env_rate_t requested_rate;
    rate_ovf_t rate_ovf;
    logic [2:1][TAG_W-1:0] tag_p;

    env_rate_counter #(
        .NUM_BANKS(NUM_BANKS),
        .OPS_PER_BANK(OPS_PER_BANK)
    ) i_env_rate_counter (
        .clk, .arst_n, .slot_en, .bank_num, .op_num,
        .ksr, .nts, .fnum, .block,
        .requested_rate,
        .rate_ovf
    );

    env_attenuation #(
        .NUM_BANKS(NUM_BANKS),
        .OPS_PER_BANK(OPS_PER_BANK)
    ) i_env_attenuation (
        .clk, .arst_n, .slot_en, .bank_num, .op_num, .key_on,
        .attack_rate, .decay_rate, .sustain_level, .release_rate,
        .rate_ovf,
        .requested_rate,
        .env_valid,
        .env_level
    );

    // output tags line up with env_level at p2.
    op_delay_line #(
        .WIDTH(TAG_W),
        .STAGES(2)
    ) i_out_tag_dly (
        .clk,
        .arst_n,
        .din({bank_num, op_num}),
        .dout(tag_p)
    );

    assign {env_bank, env_op} = tag_p[2];

endmodule

`default_nettype wire

//--- hw/env_attenuation.sv
//####################
// envelope FSM and attenuation level update.
//####################
`timescale 1ns/10ps
`default_nettype none

module env_attenuation #(
    parameter int NUM_BANKS = 2,
    parameter int OPS_PER_BANK = 18
) (
    input wire clk,
    input wire arst_n,
    input wire slot_en,
    input wire [$clog2(NUM_BANKS)-1:0] bank_num,
    input wire [$clog2(OPS_PER_BANK)-1:0] op_num,
    input wire key_on,
    input wire env_pkg::env_rate_t attack_rate,
    input wire env_pkg::env_rate_t decay_rate,
    input wire env_pkg::sustain_lvl_t sustain_level,
    input wire env_pkg::env_rate_t release_rate,
    input wire env_pkg::rate_ovf_t rate_ovf,        // overflow from the rate counter at p1.
    output env_pkg::env_rate_t requested_rate,      // rate in force at p0.
    output logic env_valid,                         // p2.
    output env_pkg::env_level_t env_level           // p2.
);

    import env_pkg::*;

    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int OP_W = $clog2(OPS_PER_BANK);
    localparam int DEPTH = NUM_BANKS * OPS_PER_BANK;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int TAG_W = 2 + SUSTAIN_LVL_W + 2 + BANK_W + OP_W;

    logic [2:0] shadow_q [DEPTH] = '{default: ENV_REC_INIT[2:0]}; // {state, key}.
    logic [IDX_W-1:0] idx_p0;
    logic [IDX_W-1:0] idx_p2;
    logic [2:0] shadow_p0;
    env_state_t state_p0;
    logic [2:1][TAG_W-1:0] tag_p;
    logic valid_p1;
    logic key_p1;
    sustain_lvl_t sl_p1;
    logic [1:0] state_dec_raw_p1;
    logic valid_p2;
    logic [BANK_W-1:0] bank_p2;
    logic [OP_W-1:0] op_p2;
    env_rec_t rec_p1;
    env_level_t rec_level_p1;
    logic [1:0] rec_state_raw_p1;
    logic rec_key_p1;
    env_state_t state_p1;
    env_level_t sustain_target_p1;
    env_level_t attack_dec_p1;
    logic [ENV_LEVEL_W:0] level_sum_p1;
    env_level_t level_next_p1;
    env_state_t state_next_p1;
    env_level_t level_q;
    env_state_t state_q;
    logic key_q;

    // rising key enters attack, key up enters release, else hold.
    function automatic env_state_t next_state(input logic key, input logic key_prev,
                                              input env_state_t state);
        if (key && !key_prev) begin
            return env_attack;
        end
        if (!key) begin
            return env_release;
        end
        return state;
    endfunction

    // state decided at p0 from the shadow so the rate is ready before the memory read.
    always_comb begin
        idx_p0 = IDX_W'(bank_num * OPS_PER_BANK + op_num);
        shadow_p0 = shadow_q[idx_p0];
        state_p0 = next_state(key_on, shadow_p0[0], env_state_t'(shadow_p0[2:1]));
        case (state_p0)
            env_attack: requested_rate = attack_rate;
            env_decay: requested_rate = decay_rate;
            env_release: requested_rate = release_rate;
            default: requested_rate = '0;           // sustain holds.
        endcase
    end

    op_delay_line #(
        .WIDTH(TAG_W),
        .STAGES(2)
    ) i_tag_dly (
        .clk,
        .arst_n,
        .din({slot_en, key_on, sustain_level, state_p0, bank_num, op_num}),
        .dout(tag_p)
    );

    always_comb begin
        {valid_p1, key_p1, sl_p1, state_dec_raw_p1} = tag_p[1][TAG_W-1:BANK_W+OP_W];
        valid_p2 = tag_p[2][TAG_W-1];
        {bank_p2, op_p2} = tag_p[2][BANK_W+OP_W-1:0];
        idx_p2 = IDX_W'(bank_p2 * OPS_PER_BANK + op_p2);
    end

    op_state_mem #(
        .WIDTH(ENV_REC_W),
        .NUM_BANKS(NUM_BANKS),
        .OPS_PER_BANK(OPS_PER_BANK),
        .INIT(ENV_REC_INIT)
    ) i_rec_mem (
        .clk,
        .we(valid_p2),
        .wbank(bank_p2),
        .waddr(op_p2),
        .wdata({level_q, state_q, key_q}),
        .re(slot_en),
        .rbank(bank_num),
        .raddr(op_num),
        .rdata(rec_p1)
    );

    // level step at p1 from the stored record and the overflow.
    always_comb begin
        {rec_level_p1, rec_state_raw_p1, rec_key_p1} = rec_p1;
        state_p1 = next_state(key_p1, rec_key_p1, env_state_t'(rec_state_raw_p1));
        sustain_target_p1 = {sl_p1, 5'b0};
        attack_dec_p1 = ENV_LEVEL_W'(rate_ovf) * (ENV_LEVEL_W'(rec_level_p1[8:4]) + 9'd1);
        level_sum_p1 = {1'b0, rec_level_p1} + (ENV_LEVEL_W + 1)'(rate_ovf);
        level_next_p1 = rec_level_p1;
        state_next_p1 = state_p1;
        case (state_p1)
            env_attack: begin
                if (attack_dec_p1 >= rec_level_p1) begin
                    level_next_p1 = '0;             // loudest level moves on to decay.
                    state_next_p1 = env_decay;
                end else begin
                    level_next_p1 = rec_level_p1 - attack_dec_p1;
                end
            end
            env_decay: begin
                if (level_sum_p1 >= {1'b0, sustain_target_p1}) begin
                    level_next_p1 = sustain_target_p1;
                    state_next_p1 = env_sustain;
                end else begin
                    level_next_p1 = level_sum_p1[ENV_LEVEL_W-1:0];
                end
            end
            env_release: begin
                if (level_sum_p1 > {1'b0, ENV_LEVEL_MAX}) begin
                    level_next_p1 = ENV_LEVEL_MAX;  // saturate at silence.
                end else begin
                    level_next_p1 = level_sum_p1[ENV_LEVEL_W-1:0];
                end
            end
            default: ;                              // sustain holds.
        endcase
    end

    always_ff @(posedge clk) begin
        level_q <= level_next_p1;
        state_q <= state_next_p1;
        key_q <= key_p1;
    end

    always_ff @(posedge clk) begin
        if (valid_p2) begin
            shadow_q[idx_p2] <= {state_q, key_q};   // same write-back as the record.
        end
    end

    assign env_valid = valid_p2;
    assign env_level = level_q;

    // shadow decision at p0 has to match the stored record seen at p1.
    a_shadow_match: assert property (@(posedge clk) disable iff (!arst_n)
        valid_p1 |-> state_p1 == env_state_t'(state_dec_raw_p1));
    a_attack_no_rise: assert property (@(posedge clk) disable iff (!arst_n)
        valid_p1 && state_p1 == env_attack |=> level_q <= $past(rec_level_p1));

endmodule

`default_nettype wire

//--- hw/env_rate_counter.sv
//####################
// key scaled effective rate and per operator
// rate counter, overflow out at p1.
//####################
`timescale 1ns/10ps
`default_nettype none

module env_rate_counter #(
    parameter int NUM_BANKS = 2,
    parameter int OPS_PER_BANK = 18
) (
    input wire clk,
    input wire arst_n,
    input wire slot_en,                             // p0 strobe.
    input wire [$clog2(NUM_BANKS)-1:0] bank_num,
    input wire [$clog2(OPS_PER_BANK)-1:0] op_num,
    input wire ksr,                                 // key scale rate.
    input wire nts,                                 // keyboard split select.
    input wire env_pkg::fnum_t fnum,
    input wire env_pkg::block_t block,
    input wire env_pkg::env_rate_t requested_rate,  // from the envelope FSM, p0.
    output env_pkg::rate_ovf_t rate_ovf             // p1.
);

    import env_pkg::*;

    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int OP_W = $clog2(OPS_PER_BANK);
    localparam int TAG_W = 2 + BANK_W + OP_W;       // strobe, rate nonzero, bank, op.

    logic ks_bit_p0;
    logic [3:0] ks_raw_p0;
    logic [3:0] ks_offset_p0;
    logic [6:0] rate_sum_p0;                        // up to 15 + 60.
    eff_rate_t eff_rate_p1;
    logic [2:0] inc_base_p1;
    logic [RATE_SUM_W-1:0] inc_p1;
    logic [RATE_SUM_W-1:0] sum_p1;
    rate_count_t counter_p1;
    rate_count_t counter_new_p2;
    logic [2:1][TAG_W-1:0] tag_p;
    logic en_p2;
    logic nz_p1;
    logic nz_p2;
    logic [BANK_W-1:0] bank_p2;
    logic [OP_W-1:0] op_p2;

    op_delay_line #(
        .WIDTH(TAG_W),
        .STAGES(2)
    ) i_tag_dly (
        .clk,
        .arst_n,
        .din({slot_en, (requested_rate != '0), bank_num, op_num}),
        .dout(tag_p)
    );

    always_comb begin
        {en_p2, nz_p2, bank_p2, op_p2} = tag_p[2];
        nz_p1 = tag_p[1][TAG_W-2];
    end

    // key scale offset, 0 to 15, quartered without ksr.
    always_comb begin
        ks_bit_p0 = nts ? fnum[8] : fnum[9];
        ks_raw_p0 = {block, ks_bit_p0};
        ks_offset_p0 = ksr ? ks_raw_p0 : (ks_raw_p0 >> 2);
        rate_sum_p0 = 7'(ks_offset_p0) + {1'b0, requested_rate, 2'b00};
    end

    always_ff @(posedge clk) begin
        if (rate_sum_p0 > 7'(EFF_RATE_MAX)) begin
            eff_rate_p1 <= EFF_RATE_MAX;            // clamp.
        end else begin
            eff_rate_p1 <= rate_sum_p0[EFF_RATE_W-1:0];
        end
    end

    op_state_mem #(
        .WIDTH(RATE_COUNT_W),
        .NUM_BANKS(NUM_BANKS),
        .OPS_PER_BANK(OPS_PER_BANK),
        .INIT('0)
    ) i_counter_mem (
        .clk,
        .we(en_p2 && nz_p2),                        // a zero rate leaves the counter.
        .wbank(bank_p2),
        .waddr(op_p2),
        .wdata(counter_new_p2),
        .re(slot_en),
        .rbank(bank_num),
        .raddr(op_num),
        .rdata(counter_p1)
    );

    // increment is (4 | low bits) << upper bits.
    always_comb begin
        inc_base_p1 = {1'b1, eff_rate_p1[1:0]};
        inc_p1 = RATE_SUM_W'(inc_base_p1) << eff_rate_p1[EFF_RATE_W-1:2];
        sum_p1 = RATE_SUM_W'(counter_p1) + inc_p1;
        rate_ovf = nz_p1 ? sum_p1[RATE_SUM_W-1:RATE_COUNT_W] : '0;
    end

    always_ff @(posedge clk) begin
        counter_new_p2 <= sum_p1[RATE_COUNT_W-1:0];  // wraps, overflow went out.
    end

    a_zero_rate_no_ovf: assert property (@(posedge clk) disable iff (!arst_n)
        slot_en && requested_rate == '0 |=> rate_ovf == '0);

endmodule

`default_nettype wire

//--- hw/op_state_mem.sv
//####################
// banked per operator memory, registered read.
//####################
`timescale 1ns/10ps
`default_nettype none

module op_state_mem #(
    parameter int WIDTH = 8,
    parameter int NUM_BANKS = 2,
    parameter int OPS_PER_BANK = 18,
    parameter logic [WIDTH-1:0] INIT = '0
) (
    input wire clk,
    input wire we,                                  // write-back at p2.
    input wire [$clog2(NUM_BANKS)-1:0] wbank,
    input wire [$clog2(OPS_PER_BANK)-1:0] waddr,
    input wire [WIDTH-1:0] wdata,
    input wire re,                                  // read at p0.
    input wire [$clog2(NUM_BANKS)-1:0] rbank,
    input wire [$clog2(OPS_PER_BANK)-1:0] raddr,
    output logic [WIDTH-1:0] rdata = INIT           // valid at p1.
);

    localparam int DEPTH = NUM_BANKS * OPS_PER_BANK;
    localparam int IDX_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH] = '{default: INIT};  // power-up value only.
    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] ridx;

    // banks sit one after the other.
    always_comb begin
        widx = IDX_W'(wbank * OPS_PER_BANK + waddr);
        ridx = IDX_W'(rbank * OPS_PER_BANK + raddr);
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[widx] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[ridx];                     // old data on a same-cycle write.
        end
    end

    // an operator revisited too soon would read a word whose
    // write-back from its previous visit has not landed yet.
    a_raw_same_cycle: assert property (@(posedge clk)
        re |-> !(we && widx == ridx));
    a_raw_next_cycle: assert property (@(posedge clk)
        re |=> !(we && widx == $past(ridx)));

endmodule

`default_nettype wire

//--- hw/op_delay_line.sv
//####################
// tag and valid delay line, every stage visible.
//####################
`timescale 1ns/10ps
`default_nettype none

module op_delay_line #(
    parameter int WIDTH = 1,
    parameter int STAGES = 2
) (
    input wire clk,
    input wire arst_n,
    input wire [WIDTH-1:0] din,
    output logic [STAGES:1][WIDTH-1:0] dout  // dout[n] is din delayed n cycles.
);

    // the whole chain clears so no stale valid survives a reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout <= '0;
        end else begin
            dout[1] <= din;                      // p1.
            for (int i = 2; i <= STAGES; i++) begin
                dout[i] <= dout[i-1];            // p2 and on.
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/env_pkg.sv
//####################
// envelope generator package: field widths, vector types,
// envelope state enum, record layout and rate constants.
//####################
`default_nettype none

package env_pkg;

    localparam int ENV_LEVEL_W = 9;           // attenuation, 0 loudest.
    localparam int ENV_RATE_W = 4;
    localparam int SUSTAIN_LVL_W = 4;
    localparam int FNUM_W = 10;
    localparam int BLOCK_W = 3;
    localparam int RATE_COUNT_W = 15;         // per operator rate counter.
    localparam int RATE_OVF_W = 3;            // envelope steps per visit.
    localparam int RATE_SUM_W = RATE_COUNT_W + RATE_OVF_W;
    localparam int EFF_RATE_W = 6;
    localparam int ENV_REC_W = ENV_LEVEL_W + 2 + 1; // level, state, key.

    typedef logic [ENV_LEVEL_W-1:0] env_level_t;
    typedef logic [ENV_RATE_W-1:0] env_rate_t;
    typedef logic [SUSTAIN_LVL_W-1:0] sustain_lvl_t; // level is field * 32.
    typedef logic [FNUM_W-1:0] fnum_t;
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [RATE_COUNT_W-1:0] rate_count_t;
    typedef logic [RATE_OVF_W-1:0] rate_ovf_t;
    typedef logic [EFF_RATE_W-1:0] eff_rate_t;  // 0 to 60.
    typedef logic [ENV_REC_W-1:0] env_rec_t;

    typedef enum logic [1:0] {
        env_attack,
        env_decay,
        env_sustain,
        env_release
    } env_state_t;

    localparam env_level_t ENV_LEVEL_MAX = 9'd511;  // silent.
    localparam eff_rate_t EFF_RATE_MAX = 6'd60;

    // record is {level, state, key}; a fresh operator is silent, released, key up.
    localparam env_rec_t ENV_REC_INIT = {ENV_LEVEL_MAX, env_release, 1'b0};

endpackage

`default_nettype wire
